/* common/decode_macros.svh */
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

`define XLEN 64
`define ILEN 32

// major opcodes of the base integer set plus system.
`define OPC_LOAD      7'b0000011
`define OPC_OP_IMM    7'b0010011
`define OPC_AUIPC     7'b0010111
`define OPC_OP_IMM_32 7'b0011011
`define OPC_STORE     7'b0100011
`define OPC_OP        7'b0110011
`define OPC_LUI       7'b0110111
`define OPC_OP_32     7'b0111011
`define OPC_BRANCH    7'b1100011
`define OPC_JALR      7'b1100111
`define OPC_JAL       7'b1101111
`define OPC_SYSTEM    7'b1110011

`endif

/* common/decode_pkg.sv */
`default_nettype none

`include "decode_macros.svh"

package decode_pkg;

    typedef logic [2:0] u3;
    typedef logic [4:0] u5;
    typedef logic [6:0] u7;
    typedef logic [`XLEN-1:0] u64;

    typedef logic [`ILEN-1:0] inst_t;

    // nop doubles as the illegal marker.
    typedef enum logic [5:0] {
        NOP,
        // register-register.
        ADD,
        SUB,
        XOR,
        OR,
        AND,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU,
        // register-immediate.
        ADDI,
        XORI,
        ORI,
        ANDI,
        SLLI,
        SRLI,
        SRAI,
        SLTI,
        SLTIU,
        // 32-bit word forms.
        ADDIW,
        SLLIW,
        SRLIW,
        SRAIW,
        ADDW,
        SUBW,
        SLLW,
        SRLW,
        SRAW,
        // loads.
        LB,
        LH,
        LW,
        LD,
        LBU,
        LHU,
        LWU,
        // stores.
        SB,
        SH,
        SW,
        SD,
        // branches.
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        // jumps and upper immediates.
        JAL,
        JALR,
        LUI,
        AUIPC,
        // zicsr.
        CSRRW,
        CSRRS,
        CSRRC,
        CSRRWI,
        CSRRSI,
        CSRRCI
    } instruction_type;

    // csr_z is the 5-bit uimm held in the rs1 field.
    typedef enum logic [2:0] {
        NONE,
        I,
        S,
        B,
        U,
        J,
        CSR_Z
    } imm_format;

    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD,
        DOUBLE
    } mem_size_t;

endpackage

`default_nettype wire

/* common/decode_if.sv */
`timescale 1ns/1ns
`default_nettype none

// fetched instruction out to the two parallel decoders, their results to the combiner.
interface decode_if;

    logic                       valid;
    decode_pkg::inst_t          inst;
    decode_pkg::u64             pc;
    decode_pkg::instruction_type op;
    decode_pkg::u64             imm;

    modport src (output valid, output inst, output pc);

    modport op_side (input inst, output op);

    modport imm_side (input inst, output imm);

    modport sink (input valid, input inst, input pc, input op, input imm);

endinterface

`default_nettype wire

/* decode/parse_instruction.sv */
`timescale 1ns/1ns
`default_nettype none

`include "decode_macros.svh"

module parse_instruction (
    decode_if.op_side bus
);

    decode_pkg::u7 opcode;
    decode_pkg::u3 funct3;
    decode_pkg::u7 funct7;
    logic [11:0]   r_key;

    assign opcode = bus.inst[6:0];
    assign funct3 = bus.inst[14:12];
    assign funct7 = bus.inst[31:25];

    // funct3 and funct7 packed as three hex digits.
    assign r_key = {1'b0, funct3, 1'b0, funct7};

    always_comb begin
        // anything not matched below stays nop.
        bus.op = decode_pkg::NOP;

        case (opcode)
            `OPC_OP: case (r_key)
                12'h000: bus.op = decode_pkg::ADD;
                12'h020: bus.op = decode_pkg::SUB;
                12'h400: bus.op = decode_pkg::XOR;
                12'h600: bus.op = decode_pkg::OR;
                12'h700: bus.op = decode_pkg::AND;
                12'h100: bus.op = decode_pkg::SLL;
                12'h500: bus.op = decode_pkg::SRL;
                12'h520: bus.op = decode_pkg::SRA;
                12'h200: bus.op = decode_pkg::SLT;
                12'h300: bus.op = decode_pkg::SLTU;
                default: bus.op = decode_pkg::NOP;
            endcase

            // shamt is 6 bits on rv64, so only the top of funct7 is checked.
            `OPC_OP_IMM: case (funct3)
                3'h0: bus.op = decode_pkg::ADDI;
                3'h4: bus.op = decode_pkg::XORI;
                3'h6: bus.op = decode_pkg::ORI;
                3'h7: bus.op = decode_pkg::ANDI;
                3'h1: begin
                    if (funct7[6:3] == 4'h0)
                        bus.op = decode_pkg::SLLI;
                end
                3'h5: begin
                    if (funct7[6:3] == 4'h0)
                        bus.op = decode_pkg::SRLI;
                    else if (funct7[6:3] == 4'h4)
                        bus.op = decode_pkg::SRAI;
                end
                3'h2: bus.op = decode_pkg::SLTI;
                3'h3: bus.op = decode_pkg::SLTIU;
                default: bus.op = decode_pkg::NOP;
            endcase

            `OPC_OP_IMM_32: case (funct3)
                3'h0: bus.op = decode_pkg::ADDIW;
                3'h1: begin
                    if (funct7 == 7'h00)
                        bus.op = decode_pkg::SLLIW;
                end
                3'h5: begin
                    if (funct7 == 7'h00)
                        bus.op = decode_pkg::SRLIW;
                    else if (funct7 == 7'h20)
                        bus.op = decode_pkg::SRAIW;
                end
                default: bus.op = decode_pkg::NOP;
            endcase

            `OPC_OP_32: case (r_key)
                12'h000: bus.op = decode_pkg::ADDW;
                12'h020: bus.op = decode_pkg::SUBW;
                12'h100: bus.op = decode_pkg::SLLW;
                12'h500: bus.op = decode_pkg::SRLW;
                12'h520: bus.op = decode_pkg::SRAW;
                default: bus.op = decode_pkg::NOP;
            endcase

            `OPC_LOAD: case (funct3)
                3'h0: bus.op = decode_pkg::LB;
                3'h1: bus.op = decode_pkg::LH;
                3'h2: bus.op = decode_pkg::LW;
                3'h3: bus.op = decode_pkg::LD;
                3'h4: bus.op = decode_pkg::LBU;
                3'h5: bus.op = decode_pkg::LHU;
                3'h6: bus.op = decode_pkg::LWU;
                default: bus.op = decode_pkg::NOP;
            endcase

            `OPC_STORE: case (funct3)
                3'h0: bus.op = decode_pkg::SB;
                3'h1: bus.op = decode_pkg::SH;
                3'h2: bus.op = decode_pkg::SW;
                3'h3: bus.op = decode_pkg::SD;
                default: bus.op = decode_pkg::NOP;
            endcase

            `OPC_BRANCH: case (funct3)
                3'h0: bus.op = decode_pkg::BEQ;
                3'h1: bus.op = decode_pkg::BNE;
                3'h4: bus.op = decode_pkg::BLT;
                3'h5: bus.op = decode_pkg::BGE;
                3'h6: bus.op = decode_pkg::BLTU;
                3'h7: bus.op = decode_pkg::BGEU;
                default: bus.op = decode_pkg::NOP;
            endcase

            `OPC_JAL: bus.op = decode_pkg::JAL;
            `OPC_JALR: begin
                if (funct3 == 3'h0)
                    bus.op = decode_pkg::JALR;
            end

            `OPC_LUI:   bus.op = decode_pkg::LUI;
            `OPC_AUIPC: bus.op = decode_pkg::AUIPC;

            // ecall and ebreak (funct3 0) are not handled.
            `OPC_SYSTEM: case (funct3)
                3'h1: bus.op = decode_pkg::CSRRW;
                3'h2: bus.op = decode_pkg::CSRRS;
                3'h3: bus.op = decode_pkg::CSRRC;
                3'h5: bus.op = decode_pkg::CSRRWI;
                3'h6: bus.op = decode_pkg::CSRRSI;
                3'h7: bus.op = decode_pkg::CSRRCI;
                default: bus.op = decode_pkg::NOP;
            endcase

            default: bus.op = decode_pkg::NOP;
        endcase
    end

endmodule

`default_nettype wire

/* decode/imm_gen.sv */
`timescale 1ns/1ns
`default_nettype none

`include "decode_macros.svh"

module imm_gen (
    decode_if.imm_side bus
);

    decode_pkg::inst_t     inst;
    decode_pkg::u7         opcode;
    decode_pkg::u3         funct3;
    decode_pkg::imm_format fmt;

    assign inst   = bus.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];

    // format from opcode alone.
    always_comb begin
        case (opcode)
            `OPC_LOAD,
            `OPC_OP_IMM,
            `OPC_OP_IMM_32,
            `OPC_JALR:   fmt = decode_pkg::I;
            `OPC_STORE:  fmt = decode_pkg::S;
            `OPC_BRANCH: fmt = decode_pkg::B;
            `OPC_LUI,
            `OPC_AUIPC:  fmt = decode_pkg::U;
            `OPC_JAL:    fmt = decode_pkg::J;
            // register csr forms carry no immediate.
            `OPC_SYSTEM: fmt = funct3[2] ? decode_pkg::CSR_Z : decode_pkg::NONE;
            default:     fmt = decode_pkg::NONE;
        endcase
    end

    // shift immediates go out as plain i-format.
    always_comb begin
        case (fmt)
            decode_pkg::I:
                bus.imm = {{(`XLEN-12){inst[31]}}, inst[31:20]};
            decode_pkg::S:
                bus.imm = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
            decode_pkg::B:
                bus.imm = {{(`XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25],
                           inst[11:8], 1'b0};
            decode_pkg::U:
                bus.imm = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'h000};
            decode_pkg::J:
                bus.imm = {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                           inst[30:21], 1'b0};
            decode_pkg::CSR_Z:
                bus.imm = {{(`XLEN-5){1'b0}}, inst[19:15]};
            default:
                bus.imm = '0;
        endcase
    end

endmodule

`default_nettype wire

/* decode/decode_combine.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_combine (
    input  wire                          clk,
    input  wire                          rst_n,
    decode_if.sink                       bus,
    output logic                         out_valid,
    output decode_pkg::instruction_type  op,
    output decode_pkg::u64               imm,
    output decode_pkg::u5                rd,
    output decode_pkg::u5                rs1,
    output decode_pkg::u5                rs2,
    output decode_pkg::u64               out_pc,
    output logic                         reg_write,
    output logic                         mem_read,
    output logic                         mem_write,
    output decode_pkg::mem_size_t        mem_size,
    output logic                         mem_unsigned,
    output logic                         branch,
    output logic                         jump,
    output logic                         illegal
);

    logic                  reg_write_d;
    logic                  mem_read_d;
    logic                  mem_write_d;
    logic                  branch_d;
    logic                  jump_d;
    logic                  illegal_d;
    logic                  mem_unsigned_d;
    decode_pkg::mem_size_t mem_size_d;
    logic                  use_rd;
    logic                  use_rs1;
    logic                  use_rs2;

    always_comb begin
        reg_write_d    = 1'b1;
        mem_read_d     = 1'b0;
        mem_write_d    = 1'b0;
        branch_d       = 1'b0;
        jump_d         = 1'b0;
        illegal_d      = 1'b0;
        mem_unsigned_d = 1'b0;
        mem_size_d     = decode_pkg::BYTE;
        use_rd         = 1'b1;
        use_rs1        = 1'b1;
        use_rs2        = 1'b0;

        case (bus.op)
            decode_pkg::ADD, decode_pkg::SUB, decode_pkg::XOR, decode_pkg::OR,
            decode_pkg::AND, decode_pkg::SLL, decode_pkg::SRL, decode_pkg::SRA,
            decode_pkg::SLT, decode_pkg::SLTU, decode_pkg::ADDW, decode_pkg::SUBW,
            decode_pkg::SLLW, decode_pkg::SRLW, decode_pkg::SRAW: use_rs2 = 1'b1;

            decode_pkg::LB, decode_pkg::LBU: begin
                mem_read_d     = 1'b1;
                mem_unsigned_d = (bus.op == decode_pkg::LBU);
            end
            decode_pkg::LH, decode_pkg::LHU: begin
                mem_read_d     = 1'b1;
                mem_size_d     = decode_pkg::HALF;
                mem_unsigned_d = (bus.op == decode_pkg::LHU);
            end
            decode_pkg::LW, decode_pkg::LWU: begin
                mem_read_d     = 1'b1;
                mem_size_d     = decode_pkg::WORD;
                mem_unsigned_d = (bus.op == decode_pkg::LWU);
            end
            decode_pkg::LD: begin
                mem_read_d = 1'b1;
                mem_size_d = decode_pkg::DOUBLE;
            end

            decode_pkg::SB, decode_pkg::SH, decode_pkg::SW, decode_pkg::SD: begin
                reg_write_d = 1'b0;
                mem_write_d = 1'b1;
                use_rd      = 1'b0;
                use_rs2     = 1'b1;
                // stores are contiguous in the enum.
                mem_size_d  = decode_pkg::mem_size_t'(bus.op - decode_pkg::SB);
            end

            decode_pkg::BEQ, decode_pkg::BNE, decode_pkg::BLT, decode_pkg::BGE,
            decode_pkg::BLTU, decode_pkg::BGEU: begin
                reg_write_d = 1'b0;
                branch_d    = 1'b1;
                use_rd      = 1'b0;
                use_rs2     = 1'b1;
            end

            decode_pkg::JAL: begin
                jump_d  = 1'b1;
                use_rs1 = 1'b0;
            end
            decode_pkg::JALR: jump_d = 1'b1;

            // rs1 field holds the uimm here.
            decode_pkg::LUI, decode_pkg::AUIPC, decode_pkg::CSRRWI, decode_pkg::CSRRSI,
            decode_pkg::CSRRCI: use_rs1 = 1'b0;

            decode_pkg::NOP: begin
                reg_write_d = 1'b0;
                illegal_d   = 1'b1;
                use_rd      = 1'b0;
                use_rs1     = 1'b0;
            end

            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            reg_write <= 1'b0;
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
            branch    <= 1'b0;
            jump      <= 1'b0;
            illegal   <= 1'b0;
        end else begin
            out_valid <= bus.valid;
            if (bus.valid) begin
                reg_write <= reg_write_d;
                mem_read  <= mem_read_d;
                mem_write <= mem_write_d;
                branch    <= branch_d;
                jump      <= jump_d;
                illegal   <= illegal_d;
            end
        end
    end

    // bundle holds between strobes.
    always_ff @(posedge clk) begin
        if (bus.valid) begin
            op           <= bus.op;
            imm          <= bus.imm;
            out_pc       <= bus.pc;
            mem_size     <= mem_size_d;
            mem_unsigned <= mem_unsigned_d;
            rd           <= use_rd  ? bus.inst[11:7]  : 5'd0;
            rs1          <= use_rs1 ? bus.inst[19:15] : 5'd0;
            rs2          <= use_rs2 ? bus.inst[24:20] : 5'd0;
        end
    end

    a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(out_valid));

    // illegal never comes with a register write or a memory access.
    a_illegal_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        illegal |-> !(reg_write || mem_read || mem_write));

    a_mem_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_read && mem_write));

endmodule

`default_nettype wire

/* verilog/decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          in_valid,
    input  wire decode_pkg::inst_t       inst,
    input  wire decode_pkg::u64          pc,
    output logic                         out_valid,
    output decode_pkg::instruction_type  op,
    output decode_pkg::u64               imm,
    output decode_pkg::u5                rd,
    output decode_pkg::u5                rs1,
    output decode_pkg::u5                rs2,
    output decode_pkg::u64               out_pc,
    output logic                         reg_write,
    output logic                         mem_read,
    output logic                         mem_write,
    output decode_pkg::mem_size_t        mem_size,
    output logic                         mem_unsigned,
    output logic                         branch,
    output logic                         jump,
    output logic                         illegal
);

    decode_if dif ();

    assign dif.valid = in_valid;
    assign dif.inst  = inst;
    assign dif.pc    = pc;

    // op and immediate decode side by side.
    parse_instruction u_parse (.bus(dif.op_side));

    imm_gen u_imm (.bus(dif.imm_side));

    decode_combine u_combine (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus         (dif.sink),
        .out_valid   (out_valid),
        .op          (op),
        .imm         (imm),
        .rd          (rd),
        .rs1         (rs1),
        .rs2         (rs2),
        .out_pc      (out_pc),
        .reg_write   (reg_write),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mem_size    (mem_size),
        .mem_unsigned(mem_unsigned),
        .branch      (branch),
        .jump        (jump),
        .illegal     (illegal)
    );

endmodule

`default_nettype wire

/* sim/tb_decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_decode_stage;

    localparam int NUM_ROWS   = 30;
    localparam int CLK_PERIOD = 100;
    localparam int SEED       = 50364;

    // major opcodes from the base isa listing.
    localparam decode_pkg::u7 OPC_LOAD      = 7'b0000011;
    localparam decode_pkg::u7 OPC_OP_IMM    = 7'b0010011;
    localparam decode_pkg::u7 OPC_AUIPC     = 7'b0010111;
    localparam decode_pkg::u7 OPC_OP_IMM_32 = 7'b0011011;
    localparam decode_pkg::u7 OPC_STORE     = 7'b0100011;
    localparam decode_pkg::u7 OPC_OP        = 7'b0110011;
    localparam decode_pkg::u7 OPC_LUI       = 7'b0110111;
    localparam decode_pkg::u7 OPC_OP_32     = 7'b0111011;
    localparam decode_pkg::u7 OPC_BRANCH    = 7'b1100011;
    localparam decode_pkg::u7 OPC_JALR      = 7'b1100111;
    localparam decode_pkg::u7 OPC_JAL       = 7'b1101111;
    localparam decode_pkg::u7 OPC_SYSTEM    = 7'b1110011;

    // flag vector runs from reg_write down to illegal.
    localparam bit [6:0] RW  = 7'b1000000;
    localparam bit [6:0] MR  = 7'b0100000;
    localparam bit [6:0] MW  = 7'b0010000;
    localparam bit [6:0] UNS = 7'b0001000;
    localparam bit [6:0] BR  = 7'b0000100;
    localparam bit [6:0] JMP = 7'b0000010;
    localparam bit [6:0] ILL = 7'b0000001;

    typedef struct {
        decode_pkg::inst_t           inst;
        decode_pkg::u64              pc;
        decode_pkg::instruction_type op;
        decode_pkg::u64              imm;
        decode_pkg::u5               rd;
        decode_pkg::u5               rs1;
        decode_pkg::u5               rs2;
        bit [6:0]                    flags;
        decode_pkg::mem_size_t       size;
    } row_t;

    logic                        clk;
    logic                        rst_n;
    logic                        in_valid;
    decode_pkg::inst_t           inst;
    decode_pkg::u64              pc;
    logic                        out_valid;
    decode_pkg::instruction_type op;
    decode_pkg::u64              imm;
    decode_pkg::u5               rd;
    decode_pkg::u5               rs1;
    decode_pkg::u5               rs2;
    decode_pkg::u64              out_pc;
    logic                        reg_write;
    logic                        mem_read;
    logic                        mem_write;
    decode_pkg::mem_size_t       mem_size;
    logic                        mem_unsigned;
    logic                        branch;
    logic                        jump;
    logic                        illegal;

    row_t rows [NUM_ROWS];
    int   n_rows = 0;
    int   cur_row = 0;
    int   check_row = 0;
    int   checked = 0;

    decode_stage dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        stop_with_error($sformatf("CHECK FAILED: %s expected 0x%0h got 0x%0h in row %0d",
                                  name, exp, act, check_row));
    endtask

    function automatic string flag_name(input int idx);
        case (idx)
            6: return "reg_write";
            5: return "mem_read";
            4: return "mem_write";
            3: return "mem_unsigned";
            2: return "branch";
            1: return "jump";
            default: return "illegal";
        endcase
    endfunction

    task automatic check_valid(input bit exp, input logic act);
        if (act !== exp)
            report_mismatch("out_valid", 64'(exp), 64'(act));
    endtask

    task automatic check_op(input decode_pkg::instruction_type exp,
                            input decode_pkg::instruction_type act);
        if (act !== exp)
            report_mismatch("op", 64'(exp), 64'(act));
    endtask

    task automatic check_imm(input string name, input decode_pkg::u64 exp,
                             input decode_pkg::u64 act);
        if (act !== exp)
            report_mismatch(name, exp, act);
    endtask

    task automatic check_reg(input string name, input decode_pkg::u5 exp,
                             input decode_pkg::u5 act);
        if (act !== exp)
            report_mismatch(name, 64'(exp), 64'(act));
    endtask

    task automatic check_flags(input bit [6:0] exp, input logic [6:0] act,
                               input decode_pkg::mem_size_t exp_size,
                               input decode_pkg::mem_size_t act_size);
        for (int i = 6; i >= 0; i--) begin
            if (act[i] !== exp[i])
                report_mismatch(flag_name(i), 64'(exp[i]), 64'(act[i]));
        end
        if (act_size !== exp_size)
            report_mismatch("mem_size", 64'(exp_size), 64'(act_size));
    endtask

    task automatic compare_row(input int idx);
        row_t       r;
        logic [6:0] act_flags;
        r         = rows[idx];
        check_row = idx;
        act_flags = {reg_write, mem_read, mem_write, mem_unsigned, branch, jump, illegal};
        check_op(r.op, op);
        check_imm("imm", r.imm, imm);
        check_imm("out_pc", r.pc, out_pc);
        check_reg("rd", r.rd, rd);
        check_reg("rs1", r.rs1, rs1);
        check_reg("rs2", r.rs2, rs2);
        check_flags(r.flags, act_flags, r.size, mem_size);
    endtask

    // instruction encoders per isa format.
    function automatic decode_pkg::inst_t r_type(input decode_pkg::u7 f7,
        input decode_pkg::u5 rs2_f, input decode_pkg::u5 rs1_f, input decode_pkg::u3 f3,
        input decode_pkg::u5 rd_f, input decode_pkg::u7 opc);
        return {f7, rs2_f, rs1_f, f3, rd_f, opc};
    endfunction

    function automatic decode_pkg::inst_t i_type(input logic [11:0] v,
        input decode_pkg::u5 rs1_f, input decode_pkg::u3 f3, input decode_pkg::u5 rd_f,
        input decode_pkg::u7 opc);
        return {v, rs1_f, f3, rd_f, opc};
    endfunction

    function automatic decode_pkg::inst_t s_type(input logic [11:0] v,
        input decode_pkg::u5 rs2_f, input decode_pkg::u5 rs1_f, input decode_pkg::u3 f3,
        input decode_pkg::u7 opc);
        return {v[11:5], rs2_f, rs1_f, f3, v[4:0], opc};
    endfunction

    function automatic decode_pkg::inst_t b_type(input logic [12:0] v,
        input decode_pkg::u5 rs2_f, input decode_pkg::u5 rs1_f, input decode_pkg::u3 f3,
        input decode_pkg::u7 opc);
        return {v[12], v[10:5], rs2_f, rs1_f, f3, v[4:1], v[11], opc};
    endfunction

    function automatic decode_pkg::inst_t u_type(input logic [19:0] v,
        input decode_pkg::u5 rd_f, input decode_pkg::u7 opc);
        return {v, rd_f, opc};
    endfunction

    function automatic decode_pkg::inst_t j_type(input logic [20:0] v,
        input decode_pkg::u5 rd_f, input decode_pkg::u7 opc);
        return {v[20], v[10:1], v[11], v[19:12], rd_f, opc};
    endfunction

    task automatic add_row(input decode_pkg::inst_t word,
        input decode_pkg::instruction_type op_exp, input decode_pkg::u64 imm_exp,
        input decode_pkg::u5 rd_exp, input decode_pkg::u5 rs1_exp,
        input decode_pkg::u5 rs2_exp, input bit [6:0] flags_exp,
        input decode_pkg::mem_size_t size_exp);
        if (n_rows < NUM_ROWS) begin
            rows[n_rows].inst  = word;
            rows[n_rows].pc    = 64'hffff_ffc0_0000_1000 + 64'(n_rows * 4);
            rows[n_rows].op    = op_exp;
            rows[n_rows].imm   = imm_exp;
            rows[n_rows].rd    = rd_exp;
            rows[n_rows].rs1   = rs1_exp;
            rows[n_rows].rs2   = rs2_exp;
            rows[n_rows].flags = flags_exp;
            rows[n_rows].size  = size_exp;
        end
        n_rows = n_rows + 1;
    endtask

    task automatic build_table();
        // alu forms.
        add_row(r_type(7'h00, 5'd2, 5'd1, 3'h0, 5'd3, OPC_OP), decode_pkg::ADD,
                64'h0, 5'd3, 5'd1, 5'd2, RW, decode_pkg::BYTE);
        add_row(r_type(7'h20, 5'd7, 5'd6, 3'h0, 5'd5, OPC_OP), decode_pkg::SUB,
                64'h0, 5'd5, 5'd6, 5'd7, RW, decode_pkg::BYTE);
        add_row(r_type(7'h20, 5'd12, 5'd11, 3'h5, 5'd10, OPC_OP), decode_pkg::SRA,
                64'h0, 5'd10, 5'd11, 5'd12, RW, decode_pkg::BYTE);
        add_row(r_type(7'h00, 5'd29, 5'd30, 3'h3, 5'd31, OPC_OP), decode_pkg::SLTU,
                64'h0, 5'd31, 5'd30, 5'd29, RW, decode_pkg::BYTE);
        add_row(i_type(12'hfff, 5'd2, 3'h0, 5'd1, OPC_OP_IMM), decode_pkg::ADDI,
                64'hffff_ffff_ffff_ffff, 5'd1, 5'd2, 5'd0, RW, decode_pkg::BYTE);
        add_row(i_type(12'h43f, 5'd5, 3'h5, 5'd4, OPC_OP_IMM), decode_pkg::SRAI,
                64'h43f, 5'd4, 5'd5, 5'd0, RW, decode_pkg::BYTE);
        add_row(i_type(12'h7ff, 5'd9, 3'h0, 5'd8, OPC_OP_IMM_32), decode_pkg::ADDIW,
                64'h7ff, 5'd8, 5'd9, 5'd0, RW, decode_pkg::BYTE);
        add_row(r_type(7'h20, 5'd15, 5'd14, 3'h0, 5'd13, OPC_OP_32), decode_pkg::SUBW,
                64'h0, 5'd13, 5'd14, 5'd15, RW, decode_pkg::BYTE);
        // loads and stores.
        add_row(i_type(12'hffc, 5'd2, 3'h0, 5'd5, OPC_LOAD), decode_pkg::LB,
                64'hffff_ffff_ffff_fffc, 5'd5, 5'd2, 5'd0, RW | MR, decode_pkg::BYTE);
        add_row(i_type(12'h008, 5'd3, 3'h5, 5'd6, OPC_LOAD), decode_pkg::LHU,
                64'h8, 5'd6, 5'd3, 5'd0, RW | MR | UNS, decode_pkg::HALF);
        add_row(i_type(12'h010, 5'd4, 3'h6, 5'd7, OPC_LOAD), decode_pkg::LWU,
                64'h10, 5'd7, 5'd4, 5'd0, RW | MR | UNS, decode_pkg::WORD);
        add_row(i_type(12'hff8, 5'd10, 3'h3, 5'd8, OPC_LOAD), decode_pkg::LD,
                64'hffff_ffff_ffff_fff8, 5'd8, 5'd10, 5'd0, RW | MR, decode_pkg::DOUBLE);
        add_row(s_type(12'hfff, 5'd9, 5'd11, 3'h0, OPC_STORE), decode_pkg::SB,
                64'hffff_ffff_ffff_ffff, 5'd0, 5'd11, 5'd9, MW, decode_pkg::BYTE);
        add_row(s_type(12'h018, 5'd12, 5'd13, 3'h3, OPC_STORE), decode_pkg::SD,
                64'h18, 5'd0, 5'd13, 5'd12, MW, decode_pkg::DOUBLE);
        add_row(s_type(12'h800, 5'd14, 5'd15, 3'h1, OPC_STORE), decode_pkg::SH,
                64'hffff_ffff_ffff_f800, 5'd0, 5'd15, 5'd14, MW, decode_pkg::HALF);
        // control transfer and upper immediates.
        add_row(b_type(13'h0010, 5'd2, 5'd1, 3'h0, OPC_BRANCH), decode_pkg::BEQ,
                64'h10, 5'd0, 5'd1, 5'd2, BR, decode_pkg::BYTE);
        add_row(b_type(13'h1ff8, 5'd4, 5'd3, 3'h1, OPC_BRANCH), decode_pkg::BNE,
                64'hffff_ffff_ffff_fff8, 5'd0, 5'd3, 5'd4, BR, decode_pkg::BYTE);
        add_row(b_type(13'h1000, 5'd6, 5'd5, 3'h7, OPC_BRANCH), decode_pkg::BGEU,
                64'hffff_ffff_ffff_f000, 5'd0, 5'd5, 5'd6, BR, decode_pkg::BYTE);
        add_row(j_type(21'h000800, 5'd1, OPC_JAL), decode_pkg::JAL,
                64'h800, 5'd1, 5'd0, 5'd0, RW | JMP, decode_pkg::BYTE);
        add_row(j_type(21'h100000, 5'd5, OPC_JAL), decode_pkg::JAL,
                64'hffff_ffff_fff0_0000, 5'd5, 5'd0, 5'd0, RW | JMP, decode_pkg::BYTE);
        add_row(i_type(12'hff0, 5'd5, 3'h0, 5'd1, OPC_JALR), decode_pkg::JALR,
                64'hffff_ffff_ffff_fff0, 5'd1, 5'd5, 5'd0, RW | JMP, decode_pkg::BYTE);
        add_row(u_type(20'h80000, 5'd10, OPC_LUI), decode_pkg::LUI,
                64'hffff_ffff_8000_0000, 5'd10, 5'd0, 5'd0, RW, decode_pkg::BYTE);
        add_row(u_type(20'h12345, 5'd11, OPC_AUIPC), decode_pkg::AUIPC,
                64'h1234_5000, 5'd11, 5'd0, 5'd0, RW, decode_pkg::BYTE);
        // csr register and immediate forms.
        add_row(i_type(12'h300, 5'd2, 3'h1, 5'd1, OPC_SYSTEM), decode_pkg::CSRRW,
                64'h0, 5'd1, 5'd2, 5'd0, RW, decode_pkg::BYTE);
        add_row(i_type(12'hc00, 5'd4, 3'h2, 5'd3, OPC_SYSTEM), decode_pkg::CSRRS,
                64'h0, 5'd3, 5'd4, 5'd0, RW, decode_pkg::BYTE);
        add_row(i_type(12'h340, 5'd31, 3'h5, 5'd5, OPC_SYSTEM), decode_pkg::CSRRWI,
                64'h1f, 5'd5, 5'd0, 5'd0, RW, decode_pkg::BYTE);
        add_row(i_type(12'hfff, 5'd17, 3'h7, 5'd6, OPC_SYSTEM), decode_pkg::CSRRCI,
                64'h11, 5'd6, 5'd0, 5'd0, RW, decode_pkg::BYTE);
        // illegal encodings. jalr keeps its i-format immediate.
        add_row(r_type(7'h01, 5'd2, 5'd1, 3'h0, 5'd3, OPC_OP), decode_pkg::NOP,
                64'h0, 5'd0, 5'd0, 5'd0, ILL, decode_pkg::BYTE);
        add_row(i_type(12'h010, 5'd5, 3'h1, 5'd1, OPC_JALR), decode_pkg::NOP,
                64'h10, 5'd0, 5'd0, 5'd0, ILL, decode_pkg::BYTE);
        add_row(32'h0000_0000, decode_pkg::NOP,
                64'h0, 5'd0, 5'd0, 5'd0, ILL, decode_pkg::BYTE);
    endtask

    initial begin : drive_rows
        int gap;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        inst     = '0;
        pc       = '0;
        void'($urandom(SEED));
        build_table();
        if (n_rows != NUM_ROWS)
            stop_with_error($sformatf("stimulus table holds %0d rows instead of %0d",
                                      n_rows, NUM_ROWS));
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            gap = int'($urandom % 4);
            repeat (gap) begin
                in_valid = 1'b0;
                @(negedge clk);
            end
            in_valid = 1'b1;
            inst     = rows[i].inst;
            pc       = rows[i].pc;
            cur_row  = i;
            @(negedge clk);
        end
        in_valid = 1'b0;
        // let the last result and a couple of idle cycles be checked.
        repeat (2) @(negedge clk);
        @(posedge clk);
        if (checked != NUM_ROWS) begin
            stop_with_error($sformatf("only %0d of %0d instructions came out of the DUT",
                                      checked, NUM_ROWS));
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

    // a strobe seen at one rising edge must show up at the next one.
    initial begin : check_outputs
        logic strobe_seen;
        int   strobe_row;
        forever begin
            @(posedge clk);
            strobe_seen = in_valid;
            strobe_row  = cur_row;
            @(negedge clk);
            check_valid(strobe_seen, out_valid);
            if (strobe_seen) begin
                compare_row(strobe_row);
                checked = checked + 1;
            end
        end
    end

    initial begin : watchdog
        #((NUM_ROWS * 5 + 20) * CLK_PERIOD);
        stop_with_error("timeout, the run did not finish in the expected time");
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+common
common/decode_pkg.sv
common/decode_if.sv
decode/parse_instruction.sv
decode/imm_gen.sv
decode/decode_combine.sv
verilog/decode_stage.sv
sim/tb_decode_stage.sv

/* Makefile */
TOP := tb_decode_stage

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f all.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
